// ==== source/rv_pkg.sv ====
package rv_pkg;

  // ------------------------------------------------
  // Widths
  // ------------------------------------------------
  localparam int xlen = 32;

  typedef logic [4:0] reg_addr_t;

  // RV32I major opcodes kept by this core
  typedef enum logic [6:0] {
    opc_op     = 7'b0110011,
    opc_op_imm = 7'b0010011,
    opc_lui    = 7'b0110111,
    opc_load   = 7'b0000011,
    opc_store  = 7'b0100011,
    opc_branch = 7'b1100011,
    opc_jal    = 7'b1101111,
    opc_system = 7'b1110011
  } opcode_e;

  // ALU operations, pass_b serves LUI
  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_slt,
    alu_sltu,
    alu_sll,
    alu_srl,
    alu_sra,
    alu_pass_b
  } alu_op_e;

  // Write-back source
  typedef enum logic [1:0] {
    res_alu,
    res_mem,
    res_pc4
  } res_src_e;

  // ------------------------------------------------
  // Stage boundaries
  // ------------------------------------------------
  typedef struct packed {
    logic            valid;
    logic [xlen-1:0] pc;
    logic [31:0]     instr;
  } if_id_t;

  typedef struct packed {
    logic            valid;
    logic            reg_write;
    logic            mem_read;
    logic            mem_write;
    logic            is_branch;
    logic            is_jal;
    logic [2:0]      funct3;
    alu_op_e         alu_op;
    logic            alu_b_imm;
    res_src_e        res_src;
    reg_addr_t       rd;
    logic [xlen-1:0] rs1_data;
    logic [xlen-1:0] rs2_data;
    logic [xlen-1:0] imm;
    logic [xlen-1:0] pc;
    logic            is_ebreak;
    logic            is_illegal;
  } id_ex_t;

  typedef struct packed {
    logic            valid;
    logic            reg_write;
    logic            mem_read;
    logic            mem_write;
    res_src_e        res_src;
    reg_addr_t       rd;
    logic [xlen-1:0] alu_result;
    logic [xlen-1:0] store_data;
    logic [xlen-1:0] pc_plus4;
    logic            is_ebreak;
    logic            is_illegal;
  } ex_mem_t;

  // Register file write port, fed back to decode
  typedef struct packed {
    logic            reg_write;
    reg_addr_t       rd;
    logic [xlen-1:0] rd_data;
  } wb_t;

endpackage

// ==== source/rv_fetch.sv ====
`timescale 1ns/1ps

module rv_fetch #(
  parameter logic [rv_pkg::xlen-1:0] reset_pc = '0
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    stall,
  input  logic                    flush,
  input  logic                    redirect,
  input  logic [rv_pkg::xlen-1:0] redirect_target,
  output logic                    imem_ren,
  output logic [rv_pkg::xlen-1:0] imem_raddr,
  input  logic [31:0]             imem_rdata,
  output rv_pkg::if_id_t          if_id
);

  logic [rv_pkg::xlen-1:0] pc;

  // SRAM style fetch, word returns in the same cycle
  assign imem_ren   = !stall;
  assign imem_raddr = pc;

  // Program counter
  // Redirect from execute takes the target, otherwise step by one word
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc <= reset_pc;
    end else if (!stall) begin
      pc <= redirect ? redirect_target : pc + rv_pkg::xlen'(4);
    end
  end

  // Fetch-to-decode register
  // Flush wins so a taken branch drops the wrong-path word
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      if_id.valid <= 1'b0;
    end else if (flush) begin
      if_id.valid <= 1'b0;
    end else if (!stall) begin
      if_id.valid <= 1'b1;
      if_id.pc    <= pc;
      if_id.instr <= imem_rdata;
    end
  end

endmodule

// ==== source/rv_decode.sv ====
`timescale 1ns/1ps

module rv_decode (
  input  logic              clk,
  input  logic              rst_n,
  input  rv_pkg::if_id_t    if_id,
  input  rv_pkg::wb_t       wb,
  input  logic              bubble,
  input  logic              flush,
  output rv_pkg::reg_addr_t rs1,
  output rv_pkg::reg_addr_t rs2,
  output logic              rs1_used,
  output logic              rs2_used,
  output rv_pkg::id_ex_t    id_ex
);

  localparam logic [31:0] ebreak_word = 32'h0010_0073;

  logic [rv_pkg::xlen-1:0] regs [32];
  logic [31:0]             instr;
  logic [2:0]              funct3;
  rv_pkg::reg_addr_t       rd;
  logic [rv_pkg::xlen-1:0] imm_i;
  logic [rv_pkg::xlen-1:0] imm_s;
  logic [rv_pkg::xlen-1:0] imm_b;
  logic [rv_pkg::xlen-1:0] imm_u;
  logic [rv_pkg::xlen-1:0] imm_j;
  logic                    writes_rd;
  logic                    use_rs1;
  logic                    use_rs2;
  rv_pkg::id_ex_t          id_next;

  assign instr  = if_id.instr;
  assign funct3 = instr[14:12];
  assign rd     = instr[11:7];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];

  // Source usage only counts for a live instruction
  assign rs1_used = if_id.valid && use_rs1;
  assign rs2_used = if_id.valid && use_rs2;

  // ------------------------------------------------
  // Immediates
  // ------------------------------------------------
  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  // funct3 to ALU operation, alt selects sub or sra
  function automatic rv_pkg::alu_op_e alu_decode(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  alu_decode = alt ? rv_pkg::alu_sub : rv_pkg::alu_add;
      3'b001:  alu_decode = rv_pkg::alu_sll;
      3'b010:  alu_decode = rv_pkg::alu_slt;
      3'b011:  alu_decode = rv_pkg::alu_sltu;
      3'b100:  alu_decode = rv_pkg::alu_xor;
      3'b101:  alu_decode = alt ? rv_pkg::alu_sra : rv_pkg::alu_srl;
      3'b110:  alu_decode = rv_pkg::alu_or;
      default: alu_decode = rv_pkg::alu_and;
    endcase
  endfunction

  // Register read with x0 tied low and write-back passed through
  function automatic logic [rv_pkg::xlen-1:0] read_reg(input rv_pkg::reg_addr_t addr);
    if (addr == 5'd0) begin
      read_reg = '0;
    end else if (wb.reg_write && wb.rd == addr) begin
      read_reg = wb.rd_data;
    end else begin
      read_reg = regs[addr];
    end
  endfunction

  // ------------------------------------------------
  // Control decode
  // ------------------------------------------------
  always_comb begin
    id_next        = '0;
    writes_rd      = 1'b0;
    use_rs1        = 1'b0;
    use_rs2        = 1'b0;
    id_next.valid  = if_id.valid;
    id_next.funct3 = funct3;
    id_next.rd     = rd;
    id_next.pc     = if_id.pc;
    case (rv_pkg::opcode_e'(instr[6:0]))
      rv_pkg::opc_op: begin
        writes_rd      = 1'b1;
        use_rs1        = 1'b1;
        use_rs2        = 1'b1;
        id_next.alu_op = alu_decode(funct3, instr[30]);
      end
      rv_pkg::opc_op_imm: begin
        writes_rd         = 1'b1;
        use_rs1           = 1'b1;
        id_next.alu_b_imm = 1'b1;
        id_next.imm       = imm_i;
        // No subtract form here, bit 30 only picks sra
        id_next.alu_op    = alu_decode(funct3, funct3 == 3'b101 && instr[30]);
      end
      rv_pkg::opc_lui: begin
        writes_rd         = 1'b1;
        id_next.alu_b_imm = 1'b1;
        id_next.imm       = imm_u;
        id_next.alu_op    = rv_pkg::alu_pass_b;
      end
      rv_pkg::opc_load: begin
        // Word loads only
        if (funct3 == 3'b010) begin
          writes_rd         = 1'b1;
          use_rs1           = 1'b1;
          id_next.mem_read  = 1'b1;
          id_next.alu_b_imm = 1'b1;
          id_next.imm       = imm_i;
          id_next.res_src   = rv_pkg::res_mem;
        end else begin
          id_next.is_illegal = 1'b1;
        end
      end
      rv_pkg::opc_store: begin
        if (funct3 == 3'b010) begin
          use_rs1           = 1'b1;
          use_rs2           = 1'b1;
          id_next.mem_write = 1'b1;
          id_next.alu_b_imm = 1'b1;
          id_next.imm       = imm_s;
        end else begin
          id_next.is_illegal = 1'b1;
        end
      end
      rv_pkg::opc_branch: begin
        // BEQ BNE BLT BGE have funct3 bit 1 clear
        if (!funct3[1]) begin
          use_rs1           = 1'b1;
          use_rs2           = 1'b1;
          id_next.is_branch = 1'b1;
          id_next.imm       = imm_b;
        end else begin
          id_next.is_illegal = 1'b1;
        end
      end
      rv_pkg::opc_jal: begin
        writes_rd       = 1'b1;
        id_next.is_jal  = 1'b1;
        id_next.imm     = imm_j;
        id_next.res_src = rv_pkg::res_pc4;
      end
      rv_pkg::opc_system: begin
        id_next.is_ebreak  = (instr == ebreak_word);
        id_next.is_illegal = (instr != ebreak_word);
      end
      default: begin
        id_next.is_illegal = 1'b1;
      end
    endcase
    // Writes to x0 are dropped here
    id_next.reg_write = writes_rd && (rd != 5'd0);
    id_next.rs1_data  = read_reg(rs1);
    id_next.rs2_data  = read_reg(rs2);
  end

  // Register file, write-back port
  always_ff @(posedge clk) begin
    if (wb.reg_write) begin
      regs[wb.rd] <= wb.rd_data;
    end
  end

  // Decode-to-execute register
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      id_ex.valid <= 1'b0;
    end else if (bubble || flush) begin
      id_ex.valid <= 1'b0;
    end else begin
      id_ex <= id_next;
    end
  end

  // x0 must never see a write from the end of the pipe
  x0_never_written : assert property (
    @(posedge clk) disable iff (!rst_n) wb.reg_write |-> wb.rd != 5'd0
  );

endmodule

// ==== source/rv_execute.sv ====
`timescale 1ns/1ps

module rv_execute (
  input  logic                    clk,
  input  logic                    rst_n,
  input  rv_pkg::id_ex_t          id_ex,
  input  logic                    flush,
  output logic                    redirect,
  output logic [rv_pkg::xlen-1:0] redirect_target,
  output rv_pkg::ex_mem_t         ex_mem
);

  logic [rv_pkg::xlen-1:0] alu_a;
  logic [rv_pkg::xlen-1:0] alu_b;
  logic [rv_pkg::xlen-1:0] alu_result;
  logic [4:0]              shamt;
  logic                    branch_cond;

  // Operand select
  assign alu_a = id_ex.rs1_data;
  assign alu_b = id_ex.alu_b_imm ? id_ex.imm : id_ex.rs2_data;
  assign shamt = alu_b[4:0];

  // ------------------------------------------------
  // ALU
  // ------------------------------------------------
  always_comb begin
    case (id_ex.alu_op)
      rv_pkg::alu_add:    alu_result = alu_a + alu_b;
      rv_pkg::alu_sub:    alu_result = alu_a - alu_b;
      rv_pkg::alu_and:    alu_result = alu_a & alu_b;
      rv_pkg::alu_or:     alu_result = alu_a | alu_b;
      rv_pkg::alu_xor:    alu_result = alu_a ^ alu_b;
      rv_pkg::alu_slt:    alu_result = rv_pkg::xlen'($signed(alu_a) < $signed(alu_b));
      rv_pkg::alu_sltu:   alu_result = rv_pkg::xlen'(alu_a < alu_b);
      rv_pkg::alu_sll:    alu_result = alu_a << shamt;
      rv_pkg::alu_srl:    alu_result = alu_a >> shamt;
      rv_pkg::alu_sra:    alu_result = $signed(alu_a) >>> shamt;
      rv_pkg::alu_pass_b: alu_result = alu_b;
      default:            alu_result = '0;
    endcase
  end

  // Branch compare on the two register values
  always_comb begin
    case (id_ex.funct3)
      3'b000:  branch_cond = (id_ex.rs1_data == id_ex.rs2_data);
      3'b001:  branch_cond = (id_ex.rs1_data != id_ex.rs2_data);
      3'b100:  branch_cond = ($signed(id_ex.rs1_data) < $signed(id_ex.rs2_data));
      3'b101:  branch_cond = ($signed(id_ex.rs1_data) >= $signed(id_ex.rs2_data));
      default: branch_cond = 1'b0;
    endcase
  end

  // Taken branch or JAL, both target pc plus immediate
  assign redirect = id_ex.valid && ((id_ex.is_branch && branch_cond) || id_ex.is_jal);
  assign redirect_target = id_ex.pc + id_ex.imm;

  // ------------------------------------------------
  // Execute-to-memory register
  // ------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ex_mem.valid <= 1'b0;
    end else if (flush) begin
      ex_mem.valid <= 1'b0;
    end else begin
      ex_mem.valid      <= id_ex.valid;
      ex_mem.reg_write  <= id_ex.reg_write;
      ex_mem.mem_read   <= id_ex.mem_read;
      ex_mem.mem_write  <= id_ex.mem_write;
      ex_mem.res_src    <= id_ex.res_src;
      ex_mem.rd         <= id_ex.rd;
      ex_mem.alu_result <= alu_result;
      ex_mem.store_data <= id_ex.rs2_data;
      ex_mem.pc_plus4   <= id_ex.pc + rv_pkg::xlen'(4);
      ex_mem.is_ebreak  <= id_ex.is_ebreak;
      ex_mem.is_illegal <= id_ex.is_illegal;
    end
  end

  // Younger slot is squashed on the cycle after a redirect
  redirect_kills_decode : assert property (
    @(posedge clk) disable iff (!rst_n) redirect |=> !id_ex.valid
  );

endmodule

// ==== source/rv_mem_wb.sv ====
`timescale 1ns/1ps

module rv_mem_wb (
  input  logic                    clk,
  input  logic                    rst_n,
  input  rv_pkg::ex_mem_t         ex_mem,
  input  logic                    freeze,
  output logic                    dmem_ren,
  output logic [rv_pkg::xlen-1:0] dmem_raddr,
  input  logic [rv_pkg::xlen-1:0] dmem_rdata,
  output logic                    dmem_we,
  output logic [rv_pkg::xlen-1:0] dmem_waddr,
  output logic [rv_pkg::xlen-1:0] dmem_wdata,
  output logic [3:0]              dmem_wstrb,
  output rv_pkg::wb_t             wb,
  output logic                    halt,
  output logic                    ebreak,
  output logic                    trap
);

  logic                    live;
  logic [rv_pkg::xlen-1:0] result;

  // Nothing past a halt touches memory or registers
  assign live = ex_mem.valid && !freeze;

  // Data memory, word access only
  assign dmem_ren   = live && ex_mem.mem_read;
  assign dmem_raddr = ex_mem.alu_result;
  assign dmem_we    = live && ex_mem.mem_write;
  assign dmem_waddr = ex_mem.alu_result;
  assign dmem_wdata = ex_mem.store_data;
  assign dmem_wstrb = 4'b1111;

  // Result select
  always_comb begin
    case (ex_mem.res_src)
      rv_pkg::res_mem: result = dmem_rdata;
      rv_pkg::res_pc4: result = ex_mem.pc_plus4;
      default:         result = ex_mem.alu_result;
    endcase
  end

  // Memory-to-writeback register and sticky halt flags
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wb.reg_write <= 1'b0;
      ebreak       <= 1'b0;
      trap         <= 1'b0;
    end else begin
      wb.reg_write <= live && ex_mem.reg_write;
      wb.rd        <= ex_mem.rd;
      wb.rd_data   <= result;
      ebreak       <= ebreak || (live && ex_mem.is_ebreak);
      trap         <= trap || (live && ex_mem.is_illegal);
    end
  end

  assign halt = ebreak || trap;

  // Decode never marks an instruction as both load and store
  no_read_and_write : assert property (
    @(posedge clk) disable iff (!rst_n) !(dmem_we && dmem_ren)
  );

endmodule

// ==== source/rv_hazard.sv ====
`timescale 1ns/1ps

module rv_hazard (
  input  rv_pkg::reg_addr_t rs1,
  input  rv_pkg::reg_addr_t rs2,
  input  logic              rs1_used,
  input  logic              rs2_used,
  input  rv_pkg::ex_mem_t   ex_mem,
  input  rv_pkg::id_ex_t    id_ex,
  input  logic              redirect,
  input  logic              halt,
  output logic              stall_if_id,
  output logic              bubble_ex,
  output logic              flush_if_id,
  output logic              freeze_all
);

  logic ex_hit;
  logic mem_hit;
  logic raw;

  // Pending write to a register that decode reads
  function automatic logic src_match(input logic valid, input logic reg_write,
                                     input rv_pkg::reg_addr_t rd);
    src_match = valid && reg_write && (rd != 5'd0) &&
                ((rs1_used && rs1 == rd) || (rs2_used && rs2 == rd));
  endfunction

  // Execute and memory hold results not yet in the register file
  always_comb begin
    ex_hit  = src_match(id_ex.valid, id_ex.reg_write, id_ex.rd);
    mem_hit = src_match(ex_mem.valid, ex_mem.reg_write, ex_mem.rd);
  end

  assign raw = ex_hit || mem_hit;

  // Flush beats a data stall, halt freezes the front end for good
  assign flush_if_id = redirect;
  assign stall_if_id = halt || (raw && !redirect);
  assign bubble_ex   = raw;
  assign freeze_all  = halt;

endmodule

// ==== source/rv_core.sv ====
`timescale 1ns/1ps

module rv_core #(
  parameter logic [rv_pkg::xlen-1:0] reset_pc = '0
) (
  input  logic                    clk,
  input  logic                    rst_n,
  output logic                    imem_ren,
  output logic [rv_pkg::xlen-1:0] imem_raddr,
  input  logic [31:0]             imem_rdata,
  output logic                    dmem_ren,
  output logic [rv_pkg::xlen-1:0] dmem_raddr,
  input  logic [rv_pkg::xlen-1:0] dmem_rdata,
  output logic                    dmem_we,
  output logic [rv_pkg::xlen-1:0] dmem_waddr,
  output logic [rv_pkg::xlen-1:0] dmem_wdata,
  output logic [3:0]              dmem_wstrb,
  output logic                    ebreak,
  output logic                    trap
);

  // ------------------------------------------------
  // Stage boundaries
  // ------------------------------------------------
  rv_pkg::if_id_t          if_id;
  rv_pkg::id_ex_t          id_ex;
  rv_pkg::ex_mem_t         ex_mem;
  rv_pkg::wb_t             wb;

  // Decode sources for the stall check
  rv_pkg::reg_addr_t       rs1;
  rv_pkg::reg_addr_t       rs2;
  logic                    rs1_used;
  logic                    rs2_used;

  // Control from execute and hazard unit
  logic                    redirect;
  logic [rv_pkg::xlen-1:0] redirect_target;
  logic                    halt;
  logic                    stall_if_id;
  logic                    bubble_ex;
  logic                    flush_if_id;
  logic                    freeze_all;

  rv_fetch #(
    .reset_pc(reset_pc)
  ) fetch_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .stall          (stall_if_id),
    .flush          (flush_if_id),
    .redirect       (redirect),
    .redirect_target(redirect_target),
    .imem_ren       (imem_ren),
    .imem_raddr     (imem_raddr),
    .imem_rdata     (imem_rdata),
    .if_id          (if_id)
  );

  rv_decode decode_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .if_id   (if_id),
    .wb      (wb),
    .bubble  (bubble_ex),
    .flush   (flush_if_id),
    .rs1     (rs1),
    .rs2     (rs2),
    .rs1_used(rs1_used),
    .rs2_used(rs2_used),
    .id_ex   (id_ex)
  );

  // Frozen execute stops feeding the memory stage
  rv_execute execute_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .id_ex          (id_ex),
    .flush          (freeze_all),
    .redirect       (redirect),
    .redirect_target(redirect_target),
    .ex_mem         (ex_mem)
  );

  rv_mem_wb mem_wb_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .ex_mem    (ex_mem),
    .freeze    (freeze_all),
    .dmem_ren  (dmem_ren),
    .dmem_raddr(dmem_raddr),
    .dmem_rdata(dmem_rdata),
    .dmem_we   (dmem_we),
    .dmem_waddr(dmem_waddr),
    .dmem_wdata(dmem_wdata),
    .dmem_wstrb(dmem_wstrb),
    .wb        (wb),
    .halt      (halt),
    .ebreak    (ebreak),
    .trap      (trap)
  );

  rv_hazard hazard_inst (
    .rs1        (rs1),
    .rs2        (rs2),
    .rs1_used   (rs1_used),
    .rs2_used   (rs2_used),
    .ex_mem     (ex_mem),
    .id_ex      (id_ex),
    .redirect   (redirect),
    .halt       (halt),
    .stall_if_id(stall_if_id),
    .bubble_ex  (bubble_ex),
    .flush_if_id(flush_if_id),
    .freeze_all (freeze_all)
  );

endmodule

// ==== tb/rv_ref_model.svh ====
`ifndef RV_REF_MODEL_SVH
`define RV_REF_MODEL_SVH

// ------------------------------------------------
// Instruction-set reference, one instruction per step
// ------------------------------------------------

// Integer ALU from the RV32I definitions
function automatic logic [31:0] ref_alu(input logic [2:0] f3, input logic alt,
                                        input logic [31:0] a, input logic [31:0] b);
  case (f3)
    3'd0:    ref_alu = alt ? a - b : a + b;
    3'd1:    ref_alu = a << b[4:0];
    3'd2:    ref_alu = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    3'd3:    ref_alu = (a < b) ? 32'd1 : 32'd0;
    3'd4:    ref_alu = a ^ b;
    3'd5:    ref_alu = alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
    3'd6:    ref_alu = a | b;
    default: ref_alu = a & b;
  endcase
endfunction

// Walks the loaded program, fills the expected store queues and ref_halt
function automatic void run_reference();
  logic [31:0] regs [32];
  logic [31:0] mem [256];
  logic [31:0] pc;
  logic [31:0] ins;
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] imm_i;
  logic [31:0] imm_s;
  logic [31:0] imm_b;
  logic [31:0] addr;
  logic [4:0]  rd;
  logic [2:0]  f3;
  logic        take;
  int          steps;
  for (int i = 0; i < 32; i++) begin
    regs[i] = '0;
  end
  for (int i = 0; i < 256; i++) begin
    mem[i] = fill_word(i);
  end
  pc       = '0;
  ref_halt = 0;
  steps    = 0;
  while (ref_halt == 0 && steps < 1000) begin
    ins   = imem[pc[7:2]];
    rd    = ins[11:7];
    f3    = ins[14:12];
    a     = regs[ins[19:15]];
    b     = regs[ins[24:20]];
    imm_i = {{20{ins[31]}}, ins[31:20]};
    imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
    imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
    steps++;
    case (ins[6:0])
      7'h33: begin
        if (rd != 0) regs[rd] = ref_alu(f3, ins[30], a, b);
        pc += 4;
      end
      7'h13: begin
        if (rd != 0) regs[rd] = ref_alu(f3, f3 == 3'd5 && ins[30], a, imm_i);
        pc += 4;
      end
      7'h37: begin
        if (rd != 0) regs[rd] = {ins[31:12], 12'b0};
        pc += 4;
      end
      7'h03: begin
        if (f3 != 3'd2) begin
          ref_halt = 2;
        end else begin
          addr = a + imm_i;
          if (rd != 0) regs[rd] = mem[addr[9:2]];
          pc += 4;
        end
      end
      7'h23: begin
        if (f3 != 3'd2) begin
          ref_halt = 2;
        end else begin
          addr = a + imm_s;
          mem[addr[9:2]] = b;
          exp_addr.push_back(addr);
          exp_data.push_back(b);
          exp_tag.push_back(tags[pc[7:2]]);
          pc += 4;
        end
      end
      7'h63: begin
        case (f3)
          3'd0: take = (a == b);
          3'd1: take = (a != b);
          3'd4: take = ($signed(a) < $signed(b));
          3'd5: take = ($signed(a) >= $signed(b));
          default: ref_halt = 2;
        endcase
        if (ref_halt == 0) pc = take ? pc + imm_b : pc + 4;
      end
      7'h6f: begin
        if (rd != 0) regs[rd] = pc + 4;
        pc = pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
      end
      7'h73: ref_halt = (ins == 32'h0010_0073) ? 1 : 2;
      default: ref_halt = 2;
    endcase
  end
endfunction

`endif

// ==== tb/rv_core_tb.sv ====
`timescale 1ns/1ps

module rv_core_tb;

  logic        clk;
  logic        rst_n;
  logic        imem_ren;
  logic [31:0] imem_raddr;
  logic [31:0] imem_rdata;
  logic        dmem_ren;
  logic [31:0] dmem_raddr;
  logic [31:0] dmem_rdata;
  logic        dmem_we;
  logic [31:0] dmem_waddr;
  logic [31:0] dmem_wdata;
  logic [3:0]  dmem_wstrb;
  logic        ebreak;
  logic        trap;

  // Program and data memories
  logic [31:0] imem [64];
  string       tags [64];
  logic [31:0] dmem [256];
  int          prog_len;
  int          soff;
  logic [31:0] rng;

  // Expected stores and the halt kind (1 ebreak, 2 trap)
  logic [31:0] exp_addr [$];
  logic [31:0] exp_data [$];
  string       exp_tag [$];
  int          ref_halt;

  int          store_idx;
  int          errors;
  int          cycles;
  int          limit;
  logic        running;

  rv_core #(
    .reset_pc(32'h0)
  ) rv_core_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .imem_ren  (imem_ren),
    .imem_raddr(imem_raddr),
    .imem_rdata(imem_rdata),
    .dmem_ren  (dmem_ren),
    .dmem_raddr(dmem_raddr),
    .dmem_rdata(dmem_rdata),
    .dmem_we   (dmem_we),
    .dmem_waddr(dmem_waddr),
    .dmem_wdata(dmem_wdata),
    .dmem_wstrb(dmem_wstrb),
    .ebreak    (ebreak),
    .trap      (trap)
  );

  always #2 clk = ~clk;

  // Same-cycle SRAM answers
  // A read without its enable returns a word the core must not use
  assign imem_rdata = imem_ren ? imem[imem_raddr[7:2]] : 32'h0;
  assign dmem_rdata = dmem_ren ? dmem[dmem_raddr[9:2]] : ~dmem[dmem_raddr[9:2]];

  always @(posedge clk) begin
    if (dmem_we) begin
      dmem[dmem_waddr[9:2]] <= dmem_wdata;
    end
  end

  // Background data that depends on every address bit
  function automatic logic [31:0] fill_word(input int idx);
    logic [31:0] byte_addr;
    byte_addr = 32'(idx) << 2;
    fill_word = (byte_addr * 32'h9e37_79b9) ^ 32'h5a5a_0f0f;
  endfunction

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    xorshift = x;
  endfunction

  `include "rv_ref_model.svh"

  // ------------------------------------------------
  // Encoders
  // ------------------------------------------------
  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    enc_r = {f7, rs2, rs1, f3, rd, 7'h33};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] op);
    enc_i = {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1);
    enc_s = {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'h23};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    enc_b = {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    enc_j = {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
  endfunction

  task automatic emit(input logic [31:0] word, input string tag);
    imem[prog_len] = word;
    tags[prog_len] = tag;
    prog_len++;
  endtask

  // Store to the next free slot above x10
  task automatic emit_sw(input logic [4:0] rs2, input string tag);
    emit(enc_s(12'(soff), rs2, 5'd10), tag);
    soff += 4;
  endtask

  function automatic logic [11:0] rand_imm();
    rng      = xorshift(rng);
    rand_imm = rng[11:0];
  endfunction

  // Branch over two shadow stores onto a marker store
  task automatic emit_branch(input logic [2:0] f3, input logic [4:0] rs1,
                             input logic [4:0] rs2, input string tag);
    emit(enc_b(13'd12, rs2, rs1, f3), tag);
    emit_sw(5'd1, tag);
    emit_sw(5'd1, tag);
    emit_sw(5'd13, tag);
  endtask

  task automatic clear_program();
    for (int i = 0; i < 64; i++) begin
      imem[i] = '0;
      tags[i] = "none";
    end
    prog_len = 0;
    soff     = 0;
  endtask

  // ------------------------------------------------
  // Programs
  // ------------------------------------------------
  task automatic build_main();
    int ld_off;
    clear_program();
    rng = xorshift(rng);
    emit({rng[31:12], 5'd1, 7'h37}, "lui");
    emit(enc_i(rand_imm(), 5'd0, 3'd0, 5'd2, 7'h13), "alu");
    emit(enc_i(rand_imm(), 5'd0, 3'd0, 5'd3, 7'h13), "alu");
    emit(enc_i(12'h100, 5'd0, 3'd0, 5'd10, 7'h13), "alu");
    emit_sw(5'd1, "lui");
    for (int f = 0; f < 8; f++) begin
      emit(enc_r(7'h00, 5'd3, 5'd2, 3'(f), 5'd4), "alu_reg");
      emit_sw(5'd4, "alu_reg");
    end
    emit(enc_r(7'h20, 5'd3, 5'd2, 3'd0, 5'd4), "alu_sub");
    emit_sw(5'd4, "alu_sub");
    emit(enc_r(7'h20, 5'd3, 5'd1, 3'd5, 5'd4), "alu_sra");
    emit_sw(5'd4, "alu_sra");
    emit(enc_i(rand_imm(), 5'd2, 3'd4, 5'd5, 7'h13), "alu_imm");
    emit_sw(5'd5, "alu_imm");
    emit(enc_i(rand_imm(), 5'd1, 3'd2, 5'd5, 7'h13), "alu_imm");
    emit_sw(5'd5, "alu_imm");
    // SRAI carries funct7 0x20 above a five-bit shift amount
    emit(enc_i(12'h400 | (rand_imm() & 12'h01f), 5'd1, 3'd5, 5'd5, 7'h13), "alu_imm");
    emit_sw(5'd5, "alu_imm");
    // Load right behind the store and a dependent add
    ld_off = soff;
    emit_sw(5'd2, "load_use");
    emit(enc_i(12'(ld_off), 5'd10, 3'd2, 5'd6, 7'h03), "load_use");
    emit(enc_r(7'h00, 5'd6, 5'd6, 3'd0, 5'd7), "load_use");
    emit_sw(5'd7, "load_use");
    emit(enc_i(12'(ld_off), 5'd10, 3'd2, 5'd6, 7'h03), "load_use");
    emit_sw(5'd6, "load_use");
    // Branch operands with a known order
    emit(enc_i(12'hffb, 5'd0, 3'd0, 5'd11, 7'h13), "branch");
    emit(enc_i(12'h003, 5'd0, 3'd0, 5'd12, 7'h13), "branch");
    emit(enc_i(12'h07e, 5'd0, 3'd0, 5'd13, 7'h13), "branch");
    emit_branch(3'd0, 5'd2, 5'd2, "beq");
    emit_branch(3'd0, 5'd11, 5'd12, "beq");
    emit_branch(3'd1, 5'd11, 5'd12, "bne");
    emit_branch(3'd1, 5'd2, 5'd2, "bne");
    emit_branch(3'd4, 5'd11, 5'd12, "blt");
    emit_branch(3'd4, 5'd12, 5'd11, "blt");
    emit_branch(3'd5, 5'd12, 5'd11, "bge");
    emit_branch(3'd5, 5'd11, 5'd12, "bge");
    emit(enc_j(21'd12, 5'd8), "jal");
    emit_sw(5'd1, "jal");
    emit_sw(5'd1, "jal");
    emit_sw(5'd8, "jal");
    emit(32'h0010_0073, "ebreak");
    emit_sw(5'd1, "ebreak");
    emit_sw(5'd2, "ebreak");
  endtask

  task automatic build_trap();
    clear_program();
    emit(enc_i(rand_imm(), 5'd0, 3'd0, 5'd2, 7'h13), "trap");
    emit(enc_i(12'h100, 5'd0, 3'd0, 5'd10, 7'h13), "trap");
    emit_sw(5'd2, "trap");
    emit_sw(5'd10, "trap");
    emit(32'hffff_ffff, "trap");
    emit_sw(5'd2, "trap");
  endtask

  // ------------------------------------------------
  // Run one program and check its end
  // ------------------------------------------------
  task automatic run_program(input string name);
    @(posedge clk);
    rst_n   <= 1'b0;
    running <= 1'b0;
    repeat (16) @(posedge clk);
    for (int i = 0; i < 256; i++) begin
      dmem[i] = fill_word(i);
    end
    exp_addr.delete();
    exp_data.delete();
    exp_tag.delete();
    run_reference();
    store_idx = 0;
    limit     = 40 * prog_len;
    rst_n   <= 1'b1;
    running <= 1'b1;
    cycles  <= 0;
    while (!(ebreak || trap)) begin
      @(posedge clk);
    end
    // Let any younger store show itself
    repeat (10) @(posedge clk);
    running <= 1'b0;
    if (ebreak !== (ref_halt == 1)) begin
      $display("Fail %s ebreak expected %0b actual %0b", name, ref_halt == 1, ebreak);
      errors++;
    end
    if (trap !== (ref_halt == 2)) begin
      $display("Fail %s trap expected %0b actual %0b", name, ref_halt == 2, trap);
      errors++;
    end
    if (store_idx != exp_addr.size()) begin
      $display("Fail %s store count expected %0d actual %0d", name,
               exp_addr.size(), store_idx);
      errors++;
    end
  endtask

  // Store compare against the reference list
  always @(posedge clk) begin
    if (rst_n && dmem_we) begin
      if (store_idx >= exp_addr.size()) begin
        $display("Unexpected store to address %h with data %h", dmem_waddr, dmem_wdata);
        errors++;
      end else begin
        if (dmem_waddr !== exp_addr[store_idx]) begin
          $display("Fail %s address expected %h actual %h", exp_tag[store_idx],
                   exp_addr[store_idx], dmem_waddr);
          errors++;
        end
        if (dmem_wdata !== exp_data[store_idx]) begin
          $display("Fail %s data expected %h actual %h", exp_tag[store_idx],
                   exp_data[store_idx], dmem_wdata);
          errors++;
        end
        if (dmem_wstrb !== 4'hf) begin
          $display("Fail %s strobe expected f actual %h", exp_tag[store_idx], dmem_wstrb);
          errors++;
        end
      end
      store_idx++;
    end
  end

  // Cycle limit per program
  always @(posedge clk) begin
    if (running) begin
      cycles <= cycles + 1;
      if (cycles > limit) begin
        $display("Timeout: the core did not halt within %0d cycles", limit);
        $display("Testbench failed");
        $finish;
      end
    end
  end

  initial begin
    clk     = 1'b0;
    rst_n   = 1'b0;
    running = 1'b0;
    cycles  = 0;
    limit   = 0;
    errors  = 0;
    rng     = 32'h8250;
    for (int i = 0; i < 256; i++) begin
      dmem[i] = fill_word(i);
    end
    build_main();
    run_program("main");
    build_trap();
    run_program("trap");
    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// ==== all.f ====
+incdir+tb
source/rv_pkg.sv
source/rv_fetch.sv
source/rv_decode.sv
source/rv_execute.sv
source/rv_mem_wb.sv
source/rv_hazard.sv
source/rv_core.sv
tb/rv_core_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= rv_core_tb
FLIST     ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "Variables: VERILATOR TOP FLIST OBJ_DIR VFLAGS"

$(OBJ_DIR)/V$(TOP): $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

test: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Testbench passed"

clean:
	rm -rf $(OBJ_DIR)
